//--- common/csr_pkg.sv
package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_NUM_W  = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    // eight hardware lines plus the inter-core line
    localparam int HWI_W      = 9;
    localparam int CRMD_W     = 9;
    localparam int LIE_W      = 13;

    typedef enum logic [2:0]
    {
        OP_CSRRD,
        OP_CSRWR,
        OP_CSRXCHG,
        OP_ERTN,
        OP_EXCP
    } csr_op_e;

    // csr numbers, compared against the raw instruction field
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h031;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h032;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h033;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    localparam logic [ECODE_W-1:0]    ECODE_INT = 6'h00;
    localparam logic [ECODE_W-1:0]    ECODE_ADE = 6'h08;
    localparam logic [ESUBCODE_W-1:0] ESUB_ADEF = 9'h000;

    // direct address mode after reset
    localparam logic [CRMD_W-1:0] CRMD_RESET = 9'h008;

    // crmd fields
    localparam int CRMD_PLV_LO = 0;
    localparam int CRMD_PLV_HI = 1;
    localparam int CRMD_IE     = 2;
    localparam int CRMD_DA     = 3;
    localparam int CRMD_PG     = 4;

    // tcfg fields
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;
    localparam int TCFG_INITVAL  = 2;

endpackage

//--- csr/csr_issue.sv
`timescale 1ns/1ns

module csr_issue (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              op_valid,
    input  logic                              stall,
    input  logic                              flush,
    input  csr_pkg::csr_op_e                  op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::XLEN-1:0]          wdata,
    input  logic [csr_pkg::XLEN-1:0]          wmask,
    input  logic [csr_pkg::XLEN-1:0]          pc,
    input  logic [csr_pkg::ECODE_W-1:0]       ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    esubcode,
    input  logic [csr_pkg::XLEN-1:0]          badv,
    input  logic                              int_pending,
    input  logic [csr_pkg::XLEN-1:0]          rd_data,
    input  logic [csr_pkg::XLEN-1:0]          era,
    input  logic [csr_pkg::XLEN-1:0]          eentry,
    output logic [csr_pkg::CSR_NUM_W-1:0]     rd_num,
    output logic [csr_pkg::XLEN-1:0]          rdata,
    output logic [csr_pkg::XLEN-1:0]          redirect_pc,
    output logic                              redirect,
    output logic                              cmt_valid,
    output csr_pkg::csr_op_e                  cmt_op,
    output logic [csr_pkg::CSR_NUM_W-1:0]     cmt_num,
    output logic [csr_pkg::XLEN-1:0]          cmt_wdata,
    output logic [csr_pkg::XLEN-1:0]          cmt_pc,
    output logic [csr_pkg::XLEN-1:0]          cmt_badv,
    output logic [csr_pkg::ECODE_W-1:0]       cmt_ecode,
    output logic [csr_pkg::ESUBCODE_W-1:0]    cmt_esubcode
);

    logic                              take_int;
    logic                              accept;
    logic                              go;
    csr_pkg::csr_op_e                  sel_op;
    logic [csr_pkg::ECODE_W-1:0]       sel_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]    sel_esub;
    logic [csr_pkg::XLEN-1:0]          sel_pc;
    logic [csr_pkg::XLEN-1:0]          sel_badv;
    logic [csr_pkg::XLEN-1:0]          wr_mask;
    logic [csr_pkg::XLEN-1:0]          merged;
    logic [csr_pkg::XLEN-1:0]          target;

    assign rd_num = csr_num;

    // IE is still set while an exception sits in commit
    assign take_int = int_pending && !(cmt_valid && cmt_op == csr_pkg::OP_EXCP);
    assign accept   = op_valid && !stall && !flush;
    assign go       = take_int || accept;

    always_comb
    begin
        if (take_int)
        begin
            sel_op    = csr_pkg::OP_EXCP;
            sel_ecode = csr_pkg::ECODE_INT;
            sel_esub  = '0;
            // no request to replace, so era keeps its value
            sel_pc    = op_valid ? pc : era;
        end
        else
        begin
            sel_op    = op;
            sel_ecode = ecode;
            sel_esub  = esubcode;
            sel_pc    = pc;
        end
    end

    // fetch address error reports the pc itself
    assign sel_badv = (sel_op == csr_pkg::OP_EXCP && sel_ecode == csr_pkg::ECODE_ADE
                       && sel_esub == csr_pkg::ESUB_ADEF) ? sel_pc : badv;

    assign wr_mask = (op == csr_pkg::OP_CSRXCHG) ? wmask : '1;
    assign merged  = (rd_data & ~wr_mask) | (wdata & wr_mask);

    always_comb
    begin
        case (sel_op)
            csr_pkg::OP_ERTN: target = era;
            csr_pkg::OP_EXCP: target = eentry;
            default:          target = pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            cmt_valid <= 1'b0;
            redirect  <= 1'b0;
            rdata     <= '0;
        end
        else
        begin
            cmt_valid <= go;
            redirect  <= go && sel_op != csr_pkg::OP_CSRRD;
            if (go)
                rdata <= rd_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (go)
        begin
            redirect_pc  <= target;
            cmt_op       <= sel_op;
            cmt_num      <= csr_num;
            cmt_wdata    <= merged;
            cmt_pc       <= sel_pc;
            cmt_badv     <= sel_badv;
            cmt_ecode    <= sel_ecode;
            cmt_esubcode <= sel_esub;
        end
    end

    // a plain read never redirects
    assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> cmt_op != csr_pkg::OP_CSRRD);

endmodule

//--- csr/csr_file.sv
`timescale 1ns/1ns

module csr_file #(
    parameter int TIMER_W = 20
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     rd_num,
    input  logic                              cmt_valid,
    input  csr_pkg::csr_op_e                  cmt_op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     cmt_num,
    input  logic [csr_pkg::XLEN-1:0]          cmt_wdata,
    input  logic [csr_pkg::XLEN-1:0]          cmt_pc,
    input  logic [csr_pkg::XLEN-1:0]          cmt_badv,
    input  logic [csr_pkg::ECODE_W-1:0]       cmt_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    cmt_esubcode,
    input  logic [csr_pkg::HWI_W-1:0]         hw_int,
    input  logic [TIMER_W-1:0]                tval,
    input  logic                              timer_int,
    output logic [csr_pkg::XLEN-1:0]          rd_data,
    output logic [csr_pkg::XLEN-1:0]          era,
    output logic [csr_pkg::XLEN-1:0]          eentry,
    output logic [csr_pkg::CRMD_W-1:0]        crmd,
    output logic                              int_pending,
    output logic [TIMER_W-1:0]                tcfg,
    output logic                              ti_clear
);

    logic [2:0]                          prmd;
    logic [csr_pkg::LIE_W-1:0]           lie;
    logic [1:0]                          estat_is;
    logic [csr_pkg::ECODE_W-1:0]         estat_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]      estat_esub;
    logic [csr_pkg::XLEN-1:0]            badv;
    logic [csr_pkg::XLEN-1:6]            eentry_hi;
    logic [csr_pkg::XLEN-1:0]            save [4];
    logic [csr_pkg::XLEN-1:0]            tid;
    logic [csr_pkg::LIE_W-1:0]           pending;
    logic                                wr_op;

    // ipi, timer, reserved, hardware lines, software lines
    assign pending = {hw_int[csr_pkg::HWI_W-1], timer_int, 1'b0,
                      hw_int[csr_pkg::HWI_W-2:0], estat_is};

    assign int_pending = crmd[csr_pkg::CRMD_IE] && |(pending & lie);
    assign eentry      = {eentry_hi, 6'b0};
    assign wr_op       = cmt_op == csr_pkg::OP_CSRWR || cmt_op == csr_pkg::OP_CSRXCHG;

    always_comb
    begin
        rd_data = '0;
        case (rd_num)
            csr_pkg::CSR_CRMD:   rd_data[csr_pkg::CRMD_W-1:0] = crmd;
            csr_pkg::CSR_PRMD:   rd_data[2:0] = prmd;
            csr_pkg::CSR_ECFG:   rd_data[csr_pkg::LIE_W-1:0] = lie;
            csr_pkg::CSR_ESTAT:  rd_data = {1'b0, estat_esub, estat_ecode, 3'b0, pending};
            csr_pkg::CSR_ERA:    rd_data = era;
            csr_pkg::CSR_BADV:   rd_data = badv;
            csr_pkg::CSR_EENTRY: rd_data = eentry;
            csr_pkg::CSR_SAVE0,
            csr_pkg::CSR_SAVE1,
            csr_pkg::CSR_SAVE2,
            csr_pkg::CSR_SAVE3:  rd_data = save[rd_num[1:0]];
            csr_pkg::CSR_TID:    rd_data = tid;
            csr_pkg::CSR_TCFG:   rd_data[TIMER_W-1:0] = tcfg;
            csr_pkg::CSR_TVAL:   rd_data[TIMER_W-1:0] = tval;
            default:             rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd        <= csr_pkg::CRMD_RESET;
            prmd        <= '0;
            lie         <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era         <= '0;
            badv        <= '0;
            eentry_hi   <= '0;
            tid         <= '0;
            tcfg        <= '0;
            ti_clear    <= 1'b0;
            for (int i = 0; i < 4; i++)
                save[i] <= '0;
        end
        else
        begin
            ti_clear <= cmt_valid && wr_op && cmt_num == csr_pkg::CSR_TICLR && cmt_wdata[0];
            if (cmt_valid)
            begin
                case (cmt_op)
                    csr_pkg::OP_CSRWR,
                    csr_pkg::OP_CSRXCHG:
                    begin
                        case (cmt_num)
                            csr_pkg::CSR_CRMD:
                            begin
                                crmd[csr_pkg::CRMD_IE:0] <= cmt_wdata[csr_pkg::CRMD_IE:0];
                                crmd[8:5] <= cmt_wdata[8:5];
                                // da and pg only move as a legal pair
                                if (cmt_wdata[csr_pkg::CRMD_DA] ^ cmt_wdata[csr_pkg::CRMD_PG])
                                begin
                                    crmd[csr_pkg::CRMD_DA] <= cmt_wdata[csr_pkg::CRMD_DA];
                                    crmd[csr_pkg::CRMD_PG] <= cmt_wdata[csr_pkg::CRMD_PG];
                                end
                            end
                            csr_pkg::CSR_PRMD:   prmd <= cmt_wdata[2:0];
                            // bit 10 is reserved
                            csr_pkg::CSR_ECFG:   lie <= cmt_wdata[csr_pkg::LIE_W-1:0] & 13'h1bff;
                            csr_pkg::CSR_ESTAT:  estat_is <= cmt_wdata[1:0];
                            csr_pkg::CSR_ERA:    era <= cmt_wdata;
                            csr_pkg::CSR_BADV:   badv <= cmt_wdata;
                            csr_pkg::CSR_EENTRY: eentry_hi <= cmt_wdata[csr_pkg::XLEN-1:6];
                            csr_pkg::CSR_SAVE0,
                            csr_pkg::CSR_SAVE1,
                            csr_pkg::CSR_SAVE2,
                            csr_pkg::CSR_SAVE3:  save[cmt_num[1:0]] <= cmt_wdata;
                            csr_pkg::CSR_TID:    tid <= cmt_wdata;
                            csr_pkg::CSR_TCFG:   tcfg <= cmt_wdata[TIMER_W-1:0];
                            default:             ;
                        endcase
                    end
                    csr_pkg::OP_EXCP:
                    begin
                        prmd <= {crmd[csr_pkg::CRMD_IE],
                                 crmd[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO]};
                        crmd[csr_pkg::CRMD_IE:csr_pkg::CRMD_PLV_LO] <= '0;
                        era         <= cmt_pc;
                        estat_ecode <= cmt_ecode;
                        estat_esub  <= cmt_esubcode;
                        badv        <= cmt_badv;
                    end
                    csr_pkg::OP_ERTN:
                    begin
                        crmd[csr_pkg::CRMD_IE:csr_pkg::CRMD_PLV_LO] <= prmd;
                        crmd[csr_pkg::CRMD_DA] <= 1'b0;
                        crmd[csr_pkg::CRMD_PG] <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // the clear pulse comes out of a commit, one cycle late
    assert property (@(posedge clk) disable iff (!rstn)
        ti_clear |-> $past(cmt_valid));

endmodule

//--- csr/csr_timer.sv
`timescale 1ns/1ns

module csr_timer #(
    parameter int TIMER_W = 20
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [TIMER_W-1:0]    tcfg,
    input  logic                  ti_clear,
    output logic [TIMER_W-1:0]    tval,
    output logic                  timer_int
);

    logic [TIMER_W-1:0]    tcfg_prev;
    logic [TIMER_W-1:0]    reload;
    logic                  en;
    logic                  periodic;

    assign en       = tcfg[csr_pkg::TCFG_EN];
    assign periodic = tcfg[csr_pkg::TCFG_PERIODIC];
    // initval is word aligned
    assign reload   = {tcfg[TIMER_W-1:csr_pkg::TCFG_INITVAL], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg_prev <= '0;
            tval      <= '0;
            timer_int <= 1'b0;
        end
        else
        begin
            tcfg_prev <= tcfg;

            if (ti_clear)
                timer_int <= 1'b0;
            else if (en && tval == 1)
                timer_int <= 1'b1;

            // new config restarts the count
            if (tcfg != tcfg_prev)
                tval <= reload;
            else if (tval == 0 && (periodic || (en && !timer_int)))
                tval <= reload;
            else if (en && tval != 0)
                tval <= tval - 1'b1;
        end
    end

    // once the config has settled the count stays within the reload value
    assert property (@(posedge clk) disable iff (!rstn)
        (tcfg == tcfg_prev) |-> (tval <= reload));

endmodule

//--- verilog/csr_unit.sv
`timescale 1ns/1ns

module csr_unit #(
    parameter int TIMER_W = 20
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              op_valid,
    input  logic                              stall,
    input  logic                              flush,
    input  csr_pkg::csr_op_e                  op,
    input  logic [csr_pkg::CSR_NUM_W-1:0]     csr_num,
    input  logic [csr_pkg::XLEN-1:0]          wdata,
    input  logic [csr_pkg::XLEN-1:0]          wmask,
    input  logic [csr_pkg::XLEN-1:0]          pc,
    input  logic [csr_pkg::XLEN-1:0]          badv,
    input  logic [csr_pkg::ECODE_W-1:0]       ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]    esubcode,
    input  logic [csr_pkg::HWI_W-1:0]         hw_int,
    output logic [csr_pkg::XLEN-1:0]          rdata,
    output logic [csr_pkg::XLEN-1:0]          redirect_pc,
    output logic                              redirect,
    output logic [csr_pkg::CRMD_W-1:0]        crmd
);

    logic [csr_pkg::CSR_NUM_W-1:0]     rd_num;
    logic [csr_pkg::XLEN-1:0]          rd_data;
    logic [csr_pkg::XLEN-1:0]          era;
    logic [csr_pkg::XLEN-1:0]          eentry;
    logic                              int_pending;
    logic                              cmt_valid;
    csr_pkg::csr_op_e                  cmt_op;
    logic [csr_pkg::CSR_NUM_W-1:0]     cmt_num;
    logic [csr_pkg::XLEN-1:0]          cmt_wdata;
    logic [csr_pkg::XLEN-1:0]          cmt_pc;
    logic [csr_pkg::XLEN-1:0]          cmt_badv;
    logic [csr_pkg::ECODE_W-1:0]       cmt_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]    cmt_esubcode;
    logic [TIMER_W-1:0]                tcfg;
    logic [TIMER_W-1:0]                tval;
    logic                              ti_clear;
    logic                              timer_int;

    csr_issue u_issue (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .stall(stall), .flush(flush),
        .op(op), .csr_num(csr_num), .wdata(wdata), .wmask(wmask), .pc(pc),
        .ecode(ecode), .esubcode(esubcode), .badv(badv), .int_pending(int_pending),
        .rd_data(rd_data), .era(era), .eentry(eentry), .rd_num(rd_num),
        .rdata(rdata), .redirect_pc(redirect_pc), .redirect(redirect),
        .cmt_valid(cmt_valid), .cmt_op(cmt_op), .cmt_num(cmt_num),
        .cmt_wdata(cmt_wdata), .cmt_pc(cmt_pc), .cmt_badv(cmt_badv),
        .cmt_ecode(cmt_ecode), .cmt_esubcode(cmt_esubcode)
    );

    csr_file #(.TIMER_W(TIMER_W)) u_file (
        .clk(clk), .rstn(rstn), .rd_num(rd_num), .cmt_valid(cmt_valid),
        .cmt_op(cmt_op), .cmt_num(cmt_num), .cmt_wdata(cmt_wdata), .cmt_pc(cmt_pc),
        .cmt_badv(cmt_badv), .cmt_ecode(cmt_ecode), .cmt_esubcode(cmt_esubcode),
        .hw_int(hw_int), .tval(tval), .timer_int(timer_int), .rd_data(rd_data),
        .era(era), .eentry(eentry), .crmd(crmd), .int_pending(int_pending),
        .tcfg(tcfg), .ti_clear(ti_clear)
    );

    csr_timer #(.TIMER_W(TIMER_W)) u_timer (
        .clk(clk), .rstn(rstn), .tcfg(tcfg), .ti_clear(ti_clear),
        .tval(tval), .timer_int(timer_int)
    );

endmodule

//--- tests/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// architectural csr state as the pipeline should see it
logic [csr_pkg::CRMD_W-1:0]     m_crmd;
logic [2:0]                     m_prmd;
logic [csr_pkg::LIE_W-1:0]      m_lie;
logic [1:0]                     m_is;
logic [csr_pkg::ECODE_W-1:0]    m_ecode;
logic [csr_pkg::ESUBCODE_W-1:0] m_esub;
logic [31:0]                    m_era;
logic [31:0]                    m_badv;
logic [31:0]                    m_eentry;
logic [31:0]                    m_save [4];
logic [31:0]                    m_tid;
logic [TIMER_W-1:0]             m_tcfg;

task automatic model_reset();
    m_crmd   = csr_pkg::CRMD_RESET;
    m_prmd   = '0;
    m_lie    = '0;
    m_is     = '0;
    m_ecode  = '0;
    m_esub   = '0;
    m_era    = '0;
    m_badv   = '0;
    m_eentry = '0;
    m_tid    = '0;
    m_tcfg   = '0;
    for (int i = 0; i < 4; i++)
        m_save[i] = '0;
endtask

function automatic logic [31:0] model_read(input logic [13:0] num, input logic [8:0] hw,
                                           input logic tint);
    logic [12:0] pend;
    // ipi on top, then timer, a hole, the hardware lines and the software lines
    pend = {hw[8], tint, 1'b0, hw[7:0], m_is};
    case (num)
        csr_pkg::CSR_CRMD:   return {23'b0, m_crmd};
        csr_pkg::CSR_PRMD:   return {29'b0, m_prmd};
        csr_pkg::CSR_ECFG:   return {19'b0, m_lie};
        csr_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b0, pend};
        csr_pkg::CSR_ERA:    return m_era;
        csr_pkg::CSR_BADV:   return m_badv;
        csr_pkg::CSR_EENTRY: return m_eentry;
        csr_pkg::CSR_SAVE0:  return m_save[0];
        csr_pkg::CSR_SAVE1:  return m_save[1];
        csr_pkg::CSR_SAVE2:  return m_save[2];
        csr_pkg::CSR_SAVE3:  return m_save[3];
        csr_pkg::CSR_TID:    return m_tid;
        csr_pkg::CSR_TCFG:   return {{(32-TIMER_W){1'b0}}, m_tcfg};
        default:             return 32'h0;
    endcase
endfunction

function automatic logic [31:0] model_target(input csr_pkg::csr_op_e kind,
                                             input logic [31:0] addr);
    if (kind == csr_pkg::OP_ERTN)
        return m_era;
    if (kind == csr_pkg::OP_EXCP)
        return m_eentry;
    return addr + 32'd4;
endfunction

task automatic model_apply(input csr_pkg::csr_op_e kind, input logic [13:0] num,
                           input logic [31:0] data, input logic [31:0] addr,
                           input logic [5:0] code, input logic [8:0] sub,
                           input logic [31:0] bad);
    if (kind == csr_pkg::OP_CSRWR || kind == csr_pkg::OP_CSRXCHG)
    begin
        case (num)
            csr_pkg::CSR_CRMD:
            begin
                m_crmd[2:0] = data[2:0];
                m_crmd[8:5] = data[8:5];
                if (data[3] != data[4])
                    m_crmd[4:3] = data[4:3];
            end
            csr_pkg::CSR_PRMD:   m_prmd = data[2:0];
            csr_pkg::CSR_ECFG:   m_lie = data[12:0] & 13'h1bff;
            csr_pkg::CSR_ESTAT:  m_is = data[1:0];
            csr_pkg::CSR_ERA:    m_era = data;
            csr_pkg::CSR_BADV:   m_badv = data;
            csr_pkg::CSR_EENTRY: m_eentry = {data[31:6], 6'b0};
            csr_pkg::CSR_SAVE0:  m_save[0] = data;
            csr_pkg::CSR_SAVE1:  m_save[1] = data;
            csr_pkg::CSR_SAVE2:  m_save[2] = data;
            csr_pkg::CSR_SAVE3:  m_save[3] = data;
            csr_pkg::CSR_TID:    m_tid = data;
            csr_pkg::CSR_TCFG:   m_tcfg = data[TIMER_W-1:0];
            default:             ;
        endcase
    end
    else if (kind == csr_pkg::OP_EXCP)
    begin
        m_prmd      = m_crmd[2:0];
        m_crmd[2:0] = 3'b0;
        m_era       = addr;
        m_ecode     = code;
        m_esub      = sub;
        m_badv      = (code == csr_pkg::ECODE_ADE && sub == csr_pkg::ESUB_ADEF) ? addr : bad;
    end
    else if (kind == csr_pkg::OP_ERTN)
    begin
        m_crmd[2:0] = m_prmd;
        m_crmd[3]   = 1'b0;
        m_crmd[4]   = 1'b1;
    end
endtask

`endif

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ns

module csr_unit_tb;

    localparam int TIMER_W = 20;

    logic                           clk;
    logic                           rstn;
    logic                           op_valid;
    logic                           stall;
    logic                           flush;
    csr_pkg::csr_op_e               op;
    logic [csr_pkg::CSR_NUM_W-1:0]  csr_num;
    logic [31:0]                    wdata;
    logic [31:0]                    wmask;
    logic [31:0]                    pc;
    logic [31:0]                    badv;
    logic [csr_pkg::ECODE_W-1:0]    ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] esubcode;
    logic [csr_pkg::HWI_W-1:0]      hw_int;
    logic [31:0]                    rdata;
    logic [31:0]                    redirect_pc;
    logic                           redirect;
    logic [csr_pkg::CRMD_W-1:0]     crmd;
    integer                         seed;
    logic                           exp_tint;
    logic [31:0]                    exp_rdata;
    logic [13:0]                    wr_nums [9];

    `include "csr_model.svh"

    csr_unit #(.TIMER_W(TIMER_W)) UUT (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .stall(stall), .flush(flush),
        .op(op), .csr_num(csr_num), .wdata(wdata), .wmask(wmask), .pc(pc),
        .badv(badv), .ecode(ecode), .esubcode(esubcode), .hw_int(hw_int),
        .rdata(rdata), .redirect_pc(redirect_pc), .redirect(redirect), .crmd(crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "%s", msg);
    endtask

    // one request, checked on the cycle after acceptance
    task automatic issue(input csr_pkg::csr_op_e kind, input logic [13:0] num,
                         input logic [31:0] data, input logic [31:0] mask,
                         input logic [31:0] addr, input logic [5:0] code,
                         input logic [8:0] sub, input logic [31:0] bad);
        logic [31:0] old;
        logic [31:0] merged;
        logic [31:0] target;
        old    = model_read(num, hw_int, exp_tint);
        merged = (kind == csr_pkg::OP_CSRXCHG) ? ((old & ~mask) | (data & mask)) : data;
        target = model_target(kind, addr);
        @(posedge clk);
        #2;
        op_valid = 1'b1;
        op       = kind;
        csr_num  = num;
        wdata    = data;
        wmask    = mask;
        pc       = addr;
        ecode    = code;
        esubcode = sub;
        badv     = bad;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
        badv     = '0;
        if (kind != csr_pkg::OP_ERTN && kind != csr_pkg::OP_EXCP)
            check_value("rdata", old, rdata);
        check_value("redirect", {31'b0, kind != csr_pkg::OP_CSRRD}, {31'b0, redirect});
        if (kind != csr_pkg::OP_CSRRD)
            check_value("redirect_pc", target, redirect_pc);
        exp_rdata = old;
        model_apply(kind, num, merged, addr, code, sub, bad);
    endtask

    task automatic read_csr(input logic [13:0] num);
        issue(csr_pkg::OP_CSRRD, num, '0, '0, 32'h1c00_0000, '0, '0, '0);
    endtask

    task automatic write_csr(input logic [13:0] num, input logic [31:0] data);
        issue(csr_pkg::OP_CSRWR, num, data, '0, 32'h1c00_0100, '0, '0, '0);
    endtask

    // waits for an interrupt redirect that is not tied to a request
    task automatic wait_redirect(input int limit);
        int n;
        n = 0;
        // the redirect of the request just issued is still showing
        @(posedge clk);
        #2;
        while (!redirect)
        begin
            if (n == limit)
                fail_now("timeout: no interrupt redirect seen");
            @(posedge clk);
            #2;
            n++;
        end
        check_value("redirect_pc", m_eentry, redirect_pc);
        model_apply(csr_pkg::OP_EXCP, '0, '0, m_era, csr_pkg::ECODE_INT, '0, '0);
    endtask

    task automatic poll_timer(input int limit);
        int n;
        n = 0;
        forever
        begin
            if (n == limit)
                fail_now("timeout: timer bit never showed in ESTAT");
            @(posedge clk);
            #2;
            op_valid = 1'b1;
            op       = csr_pkg::OP_CSRRD;
            csr_num  = csr_pkg::CSR_ESTAT;
            @(posedge clk);
            #2;
            op_valid = 1'b0;
            n++;
            if (rdata[11])
                break;
        end
    endtask

    initial
    begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [13:0] num;
        seed      = 32'ha4df_0d86;
        exp_tint  = 1'b0;
        exp_rdata = '0;
        wr_nums   = '{csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
                      csr_pkg::CSR_SAVE3, csr_pkg::CSR_ERA, csr_pkg::CSR_EENTRY,
                      csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_TID};
        rstn     = 1'b0;
        op_valid = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        op       = csr_pkg::OP_CSRRD;
        csr_num  = '0;
        wdata    = '0;
        wmask    = '0;
        pc       = '0;
        badv     = '0;
        ecode    = '0;
        esubcode = '0;
        hw_int   = '0;
        model_reset();
        repeat (4) @(posedge clk);
        #2;
        rstn = 1'b1;

        // reset values
        check_value("crmd", {23'b0, csr_pkg::CRMD_RESET}, {23'b0, crmd});
        check_value("rdata", 32'h0, rdata);
        repeat (3)
        begin
            @(posedge clk);
            #2;
            check_value("redirect", 32'h0, {31'b0, redirect});
        end
        for (int i = 0; i < 4; i++)
            read_csr(wr_nums[i]);

        // random writes, exchanges and reads
        for (int i = 0; i < 60; i++)
        begin
            r   = $random(seed);
            r2  = $random(seed);
            num = wr_nums[r[7:4] % 9];
            case (r[1:0])
                2'd0:    issue(csr_pkg::OP_CSRWR, num, r2, '0, {r[31:2], 2'b0}, '0, '0, '0);
                2'd1:    issue(csr_pkg::OP_CSRXCHG, num, r2, $random(seed),
                               {r[31:2], 2'b0}, '0, '0, '0);
                default: ;
            endcase
            read_csr(num);
        end

        // exceptions and returns, interrupts off
        for (int i = 0; i < 12; i++)
        begin
            r  = $random(seed);
            r2 = $random(seed);
            if (r[0])
                issue(csr_pkg::OP_EXCP, '0, '0, '0, r2, csr_pkg::ECODE_ADE,
                      csr_pkg::ESUB_ADEF, $random(seed));
            else
                issue(csr_pkg::OP_EXCP, '0, '0, '0, r2, r[13:8], r[24:16], $random(seed));
            read_csr(csr_pkg::CSR_ERA);
            read_csr(csr_pkg::CSR_BADV);
            read_csr(csr_pkg::CSR_ESTAT);
            issue(csr_pkg::OP_ERTN, '0, '0, '0, '0, '0, '0, '0);
            @(posedge clk);
            #2;
            check_value("crmd", {23'b0, m_crmd}, {23'b0, crmd});
        end

        // flushed and stalled requests leave no trace
        for (int i = 0; i < 8; i++)
        begin
            r2 = $random(seed);
            @(posedge clk);
            #2;
            op_valid = 1'b1;
            op       = csr_pkg::OP_CSRWR;
            csr_num  = wr_nums[r2[3:0] % 9];
            wdata    = $random(seed);
            flush    = r2[8];
            stall    = !r2[8];
            @(posedge clk);
            #2;
            op_valid = 1'b0;
            flush    = 1'b0;
            stall    = 1'b0;
            check_value("redirect", 32'h0, {31'b0, redirect});
            check_value("rdata", exp_rdata, rdata);
            read_csr(csr_num);
        end

        // timer interrupt
        write_csr(csr_pkg::CSR_CRMD, 32'h0);
        write_csr(csr_pkg::CSR_ECFG, 32'h800);
        write_csr(csr_pkg::CSR_TCFG, 32'h21);
        poll_timer(100);
        exp_tint = 1'b1;
        write_csr(csr_pkg::CSR_CRMD, 32'h4);
        wait_redirect(20);
        read_csr(csr_pkg::CSR_ESTAT);
        write_csr(csr_pkg::CSR_TCFG, 32'h0);
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        exp_tint = 1'b0;
        // clear pulse reaches the timer one cycle after the commit
        @(posedge clk);
        #2;
        read_csr(csr_pkg::CSR_ESTAT);

        // hardware interrupt replaces a read
        write_csr(csr_pkg::CSR_ECFG, 32'h4);
        write_csr(csr_pkg::CSR_CRMD, 32'h4);
        r = $random(seed);
        @(posedge clk);
        #2;
        hw_int   = 9'h001;
        op_valid = 1'b1;
        op       = csr_pkg::OP_CSRRD;
        csr_num  = csr_pkg::CSR_SAVE0;
        pc       = r;
        @(posedge clk);
        #2;
        op_valid = 1'b0;
        hw_int   = '0;
        check_value("redirect", 32'h1, {31'b0, redirect});
        check_value("redirect_pc", m_eentry, redirect_pc);
        model_apply(csr_pkg::OP_EXCP, '0, '0, r, csr_pkg::ECODE_INT, '0, '0);
        read_csr(csr_pkg::CSR_ERA);
        read_csr(csr_pkg::CSR_ESTAT);
        check_value("crmd", {23'b0, m_crmd}, {23'b0, crmd});

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+tests
common/csr_pkg.sv
csr/csr_issue.sv
csr/csr_file.sv
csr/csr_timer.sv
verilog/csr_unit.sv
tests/csr_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
